/* rtl/ifu_pkg.sv */
////////////////////
// fetch unit shared widths, opcodes
// and packet types
////////////////////

`default_nettype none

package ifu_pkg;

  localparam int xlen     = 32;
  localparam int qw_bytes = 8;
  localparam int fq_depth = 4;

  // queue pointer and occupancy widths
  localparam int fq_ptr_w = $clog2(fq_depth);
  localparam int fq_cnt_w = $clog2(fq_depth + 1);
  localparam logic [fq_cnt_w-1:0] fq_depth_cnt = fq_cnt_w'(fq_depth);

  // addi x0, x0, 0
  localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

  ////////////////////
  // rv32i major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_fence  = 7'b0001111;
  localparam logic [6:0] op_system = 7'b1110011;

  // halfword and quadword addresses
  typedef logic [31:1] pc_t;
  typedef logic [31:3] qaddr_t;

  typedef struct packed {
    qaddr_t                   qaddr;
    logic [8*qw_bytes-1:0]    data;
  } fetch_pkt_t;

  ////////////////////
  // two views of one instruction word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv32_fields_t;

  typedef struct packed {
    logic [15:0] upper;
    logic [2:0]  funct3;
    logic        bit12;
    logic [4:0]  rd_rs1;
    logic [4:0]  rs2;
    logic [1:0]  op;
  } rvc_fields_t;

  typedef union packed {
    rv32_fields_t rv32;
    rvc_fields_t  rvc;
  } instr_u;

  typedef struct packed {
    pc_t             pc;
    logic [xlen-1:0] instr;
    logic            comp;
    logic            br;
    logic            jal;
    logic            jalr;
    logic            illegal;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
  } issue_pkt_t;

  typedef struct packed {
    logic valid;
    pc_t  pc;
  } redir_t;

endpackage

`default_nettype wire

/* rtl/ifu_pc_ctrl.sv */
////////////////////
// fetch address, request strobe
// and stale response discard
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ifu_pc_ctrl (
  input  logic                            clk,
  input  logic                            reset_sync,
  input  ifu_pkg::redir_t                 exu_redir,
  input  ifu_pkg::redir_t                 jump_redir,
  input  logic                            imem_rvalid,
  input  logic [8*ifu_pkg::qw_bytes-1:0]  imem_rdata,
  input  logic [ifu_pkg::fq_cnt_w-1:0]    queue_free,
  output logic                            imem_req,
  output ifu_pkg::qaddr_t                 imem_addr,
  output logic                            fq_wr,
  output ifu_pkg::fetch_pkt_t             fq_data,
  output ifu_pkg::redir_t                 flush
);

  ifu_pkg::qaddr_t fetch_qa;
  ifu_pkg::qaddr_t qa_next;
  logic            busy;
  logic            discard;
  logic            room;
  logic            can_req;

  // execute redirect has priority over a predecoded jump
  always_comb begin
    flush.valid = exu_redir.valid | jump_redir.valid;
    flush.pc    = exu_redir.valid ? exu_redir.pc : jump_redir.pc;
  end

  // response goes to the queue unless stale or flushed
  assign fq_wr         = imem_rvalid & ~discard & ~flush.valid;
  assign fq_data.qaddr = imem_addr;
  assign fq_data.data  = imem_rdata;

  always_comb begin
    qa_next = fetch_qa;
    if (flush.valid) begin
      qa_next = flush.pc[31:3];
    end else if (fq_wr) begin
      qa_next = fetch_qa + 29'd1;
    end
  end

  // a response landing this cycle still holds a slot
  assign room = queue_free > {{(ifu_pkg::fq_cnt_w-1){1'b0}}, busy};

  // one request in flight, none in a flush cycle
  assign can_req = (~busy | imem_rvalid) & room & ~flush.valid;

  always_ff @(posedge clk) begin
    if (reset_sync) begin
      fetch_qa <= '0;
      busy     <= 1'b0;
      discard  <= 1'b0;
      imem_req <= 1'b0;
    end else begin
      fetch_qa <= qa_next;
      imem_req <= can_req;
      if (can_req) begin
        busy <= 1'b1;
      end else if (imem_rvalid) begin
        busy <= 1'b0;
      end
      // redirect with a response still out, drop it when it lands
      if (imem_rvalid) begin
        discard <= 1'b0;
      end else if (flush.valid && busy) begin
        discard <= 1'b1;
      end
    end
  end

  // address of the request in flight
  always_ff @(posedge clk) begin
    if (can_req) begin
      imem_addr <= qa_next;
    end
  end

endmodule

`default_nettype wire

/* rtl/ifu_fetch_queue.sv */
////////////////////
// fetched quadword FIFO
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ifu_fetch_queue (
  input  logic                         clk,
  input  logic                         reset_sync,
  input  logic                         flush,
  input  logic                         wr,
  input  ifu_pkg::fetch_pkt_t          wr_data,
  input  logic                         rd,
  output ifu_pkg::fetch_pkt_t          rd_data,
  output logic                         empty,
  output logic [ifu_pkg::fq_cnt_w-1:0] free_slots
);

  ifu_pkg::fetch_pkt_t mem [ifu_pkg::fq_depth];

  logic [ifu_pkg::fq_ptr_w-1:0] wr_ptr;
  logic [ifu_pkg::fq_ptr_w-1:0] rd_ptr;
  logic [ifu_pkg::fq_cnt_w-1:0] count;
  logic                         full;
  logic                         do_wr;
  logic                         do_rd;

  assign full       = (count == ifu_pkg::fq_depth_cnt);
  assign empty      = (count == '0);
  assign free_slots = ifu_pkg::fq_depth_cnt - count;

  assign do_wr = wr & ~full & ~flush;
  assign do_rd = rd & ~empty & ~flush;

  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset_sync || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/ifu_aligner.sv */
////////////////////
// halfword aligner with spanning
// parcel buffer
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ifu_aligner (
  input  logic                clk,
  input  logic                reset_sync,
  input  logic                flush,
  input  ifu_pkg::pc_t        flush_pc,
  input  ifu_pkg::fetch_pkt_t head,
  input  logic                head_valid,
  input  logic                accept,
  output logic                pop,
  output ifu_pkg::instr_u     cand_word,
  output ifu_pkg::pc_t        cand_pc,
  output logic                cand_avail
);

  logic [3:0][15:0] halves;
  logic [1:0]       off;
  logic [1:0]       off_p1;
  logic [1:0]       off_adv;
  logic [15:0]      lo_half;
  logic [15:0]      hi_half;
  logic             is32;
  logic             last;
  logic             span_take;
  logic             span_valid;
  logic [15:0]      span_half;

  assign halves  = head.data;
  assign off_p1  = off + 2'd1;
  assign lo_half = halves[off];
  assign hi_half = halves[off_p1];
  assign is32    = (lo_half[1:0] == 2'b11);

  ////////////////////
  // candidate selection
  always_comb begin
    cand_word  = {16'h0000, lo_half};
    cand_pc    = {head.qaddr, off};
    cand_avail = head_valid;
    off_adv    = off_p1;
    last       = (off == 2'd3);
    span_take  = 1'b0;
    if (span_valid) begin
      // low half from the previous quadword, high half at offset 0
      cand_word = {halves[0], span_half};
      cand_pc   = {head.qaddr - 29'd1, 2'b11};
      off_adv   = 2'd1;
      last      = 1'b0;
    end else if (is32) begin
      cand_word = {hi_half, lo_half};
      off_adv   = off + 2'd2;
      last      = (off == 2'd2);
      if (off == 2'd3) begin
        // crosses into the next quadword
        cand_avail = 1'b0;
        last       = 1'b0;
        span_take  = head_valid;
      end
    end
  end

  // head is done after its last halfword or a spanning capture
  assign pop = (accept & last) | span_take;

  ////////////////////
  // offset and spanning state
  always_ff @(posedge clk) begin
    if (reset_sync) begin
      off        <= 2'd0;
      span_valid <= 1'b0;
    end else if (flush) begin
      off        <= flush_pc[2:1];
      span_valid <= 1'b0;
    end else if (span_take) begin
      off        <= 2'd0;
      span_valid <= 1'b1;
    end else if (accept) begin
      // wraps to zero past the end of the quadword
      off        <= off_adv;
      span_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (span_take) begin
      span_half <= lo_half;
    end
  end

endmodule

`default_nettype wire

/* rtl/ifu_predecode.sv */
////////////////////
// predecoder and jump target
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ifu_predecode (
  input  ifu_pkg::instr_u     cand_word,
  input  ifu_pkg::pc_t        cand_pc,
  input  logic                cand_avail,
  input  logic                accept,
  output ifu_pkg::issue_pkt_t cand_pkt,
  output ifu_pkg::redir_t     jump_redir
);

  ifu_pkg::rv32_fields_t f32;
  ifu_pkg::rvc_fields_t  f16;
  logic [31:0]           w;
  logic [31:0]           j_imm;
  logic [31:0]           cj_imm;
  logic [31:0]           imm;
  logic                  supported;

  assign f32 = cand_word.rv32;
  assign f16 = cand_word.rvc;
  assign w   = cand_word;

  // rv32i opcodes this core accepts
  always_comb begin
    case (f32.opcode)
      ifu_pkg::op_lui, ifu_pkg::op_auipc, ifu_pkg::op_jal,
      ifu_pkg::op_branch, ifu_pkg::op_load, ifu_pkg::op_store,
      ifu_pkg::op_imm, ifu_pkg::op_reg, ifu_pkg::op_fence,
      ifu_pkg::op_system: supported = 1'b1;
      ifu_pkg::op_jalr:   supported = (f32.funct3 == 3'b000);
      default:            supported = 1'b0;
    endcase
  end

  always_comb begin
    cand_pkt       = '0;
    cand_pkt.pc    = cand_pc;
    cand_pkt.instr = w;
    cand_pkt.comp  = (f16.op != 2'b11);
    if (cand_pkt.comp) begin
      // c.beqz, c.bnez
      cand_pkt.br      = (f16.op == 2'b01) && (f16.funct3[2:1] == 2'b11);
      // c.j only, writes no register
      cand_pkt.jal     = (f16.op == 2'b01) && (f16.funct3 == 3'b101);
      // c.jr and c.jalr
      cand_pkt.jalr    = (f16.op == 2'b10) && (f16.funct3 == 3'b100) &&
                         (f16.rs2 == 5'd0) && (f16.rd_rs1 != 5'd0);
      cand_pkt.rd      = cand_pkt.jal ? 5'd0 : f16.rd_rs1;
      cand_pkt.rs1     = f16.rd_rs1;
      cand_pkt.rs2     = f16.rs2;
      cand_pkt.illegal = (w[15:0] == 16'h0000);
    end else begin
      cand_pkt.br      = (f32.opcode == ifu_pkg::op_branch);
      cand_pkt.jal     = (f32.opcode == ifu_pkg::op_jal);
      cand_pkt.jalr    = (f32.opcode == ifu_pkg::op_jalr);
      cand_pkt.rd      = f32.rd;
      cand_pkt.rs1     = f32.rs1;
      cand_pkt.rs2     = f32.rs2;
      cand_pkt.illegal = ~supported;
    end
  end

  ////////////////////
  // jump immediates
  assign j_imm  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  assign cj_imm = {{21{w[12]}}, w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
  assign imm    = cand_pkt.comp ? cj_imm : j_imm;

  // redirect only once the jump itself is taken by the issue register
  assign jump_redir.valid = cand_avail & accept & cand_pkt.jal;
  assign jump_redir.pc    = cand_pc + imm[31:1];

endmodule

`default_nettype wire

/* rtl/ifu_issue.sv */
////////////////////
// issue register
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ifu_issue (
  input  logic                clk,
  input  logic                reset_sync,
  input  logic                flush,
  input  logic                stall,
  input  ifu_pkg::issue_pkt_t cand_pkt,
  input  logic                cand_avail,
  output logic                accept,
  output logic                issue_valid,
  output ifu_pkg::issue_pkt_t issue_pkt
);

  ifu_pkg::issue_pkt_t pkt_q;

  // take a new one when empty or the decode stage moves on
  assign accept = cand_avail & (~stall | ~issue_valid);

  always_ff @(posedge clk) begin
    if (reset_sync || flush) begin
      issue_valid <= 1'b0;
    end else if (accept) begin
      issue_valid <= 1'b1;
    end else if (!stall) begin
      issue_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pkt_q <= cand_pkt;
    end
  end

  // empty slot shows a nop
  always_comb begin
    issue_pkt = pkt_q;
    if (!issue_valid) begin
      issue_pkt       = '0;
      issue_pkt.instr = ifu_pkg::nop_instr;
    end
  end

endmodule

`default_nettype wire

/* rtl/ifu_top.sv */
////////////////////
// instruction fetch unit top
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ifu_top (
  input  logic                           clk,
  input  logic                           reset_sync,
  output logic                           imem_req,
  output ifu_pkg::qaddr_t                imem_addr,
  input  logic                           imem_rvalid,
  input  logic [8*ifu_pkg::qw_bytes-1:0] imem_rdata,
  input  ifu_pkg::redir_t                exu_redir,
  input  logic                           dec_stall,
  output logic                           issue_valid,
  output ifu_pkg::issue_pkt_t            issue_pkt
);

  ifu_pkg::redir_t              jump_redir;
  ifu_pkg::redir_t              flush;
  logic                         fq_wr;
  ifu_pkg::fetch_pkt_t          fq_data;
  logic [ifu_pkg::fq_cnt_w-1:0] fq_free;
  ifu_pkg::fetch_pkt_t          fq_head;
  logic                         fq_empty;
  logic                         fq_pop;
  ifu_pkg::instr_u              cand_word;
  ifu_pkg::pc_t                 cand_pc;
  logic                         cand_avail;
  ifu_pkg::issue_pkt_t          cand_pkt;
  logic                         accept;

  ifu_pc_ctrl ifu_pc_ctrl_i (
    .clk        (clk),
    .reset_sync (reset_sync),
    .exu_redir  (exu_redir),
    .jump_redir (jump_redir),
    .imem_rvalid(imem_rvalid),
    .imem_rdata (imem_rdata),
    .queue_free (fq_free),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .fq_wr      (fq_wr),
    .fq_data    (fq_data),
    .flush      (flush)
  );

  ifu_fetch_queue ifu_fetch_queue_i (
    .clk       (clk),
    .reset_sync(reset_sync),
    .flush     (flush.valid),
    .wr        (fq_wr),
    .wr_data   (fq_data),
    .rd        (fq_pop),
    .rd_data   (fq_head),
    .empty     (fq_empty),
    .free_slots(fq_free)
  );

  ifu_aligner ifu_aligner_i (
    .clk       (clk),
    .reset_sync(reset_sync),
    .flush     (flush.valid),
    .flush_pc  (flush.pc),
    .head      (fq_head),
    .head_valid(!fq_empty),
    .accept    (accept),
    .pop       (fq_pop),
    .cand_word (cand_word),
    .cand_pc   (cand_pc),
    .cand_avail(cand_avail)
  );

  ifu_predecode ifu_predecode_i (
    .cand_word (cand_word),
    .cand_pc   (cand_pc),
    .cand_avail(cand_avail),
    .accept    (accept),
    .cand_pkt  (cand_pkt),
    .jump_redir(jump_redir)
  );

  // a jump is loaded here in its own flush cycle, so only execute clears it
  ifu_issue ifu_issue_i (
    .clk        (clk),
    .reset_sync (reset_sync),
    .flush      (exu_redir.valid),
    .stall      (dec_stall),
    .cand_pkt   (cand_pkt),
    .cand_avail (cand_avail),
    .accept     (accept),
    .issue_valid(issue_valid),
    .issue_pkt  (issue_pkt)
  );

endmodule

`default_nettype wire

/* verification/ifu_assertions.sv */
////////////////////
// concurrent checks on the fetch unit ports
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ifu_assertions (
  input logic                clk,
  input logic                reset_sync,
  input logic                imem_req,
  input logic                imem_rvalid,
  input ifu_pkg::redir_t     exu_redir,
  input logic                dec_stall,
  input logic                issue_valid,
  input ifu_pkg::issue_pkt_t issue_pkt
);

  logic outstanding;

  // set by a request, cleared by its response
  always_ff @(posedge clk) begin
    if (reset_sync) begin
      outstanding <= 1'b0;
    end else if (imem_req) begin
      outstanding <= 1'b1;
    end else if (imem_rvalid) begin
      outstanding <= 1'b0;
    end
  end

  req_single: assert property (@(posedge clk) disable iff (reset_sync)
    imem_req |-> !outstanding)
    else $error("memory request raised while a response is still outstanding");

  req_pulse: assert property (@(posedge clk) disable iff (reset_sync)
    imem_req |=> !imem_req)
    else $error("memory request held longer than one cycle");

  // execute redirect may still clear a stalled slot
  stall_hold: assert property (@(posedge clk) disable iff (reset_sync)
    (issue_valid && dec_stall && !exu_redir.valid) |=> (issue_valid && $stable(issue_pkt)))
    else $error("issued instruction changed or dropped while decode was stalling");

  reset_idle: assert property (@(posedge clk)
    reset_sync |=> (!issue_valid && !imem_req))
    else $error("issue valid or memory request high right after reset");

endmodule

`default_nettype wire

/* verification/ifu_tb.sv */
////////////////////
// fetch unit testbench with random program memory
// reference model and watchdog
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ifu_tb;

  localparam int n_instr  = 400;
  localparam int max_lat  = 6;
  localparam int mem_half = 512;

  // filler opcodes, the last one is unsupported
  localparam logic [10:0][6:0] op_list = {
    ifu_pkg::op_lui, ifu_pkg::op_auipc, ifu_pkg::op_jalr, ifu_pkg::op_branch,
    ifu_pkg::op_load, ifu_pkg::op_store, ifu_pkg::op_imm, ifu_pkg::op_reg,
    ifu_pkg::op_fence, ifu_pkg::op_system, 7'b0101011
  };

  logic                           clk;
  logic                           reset_sync;
  logic                           imem_req;
  ifu_pkg::qaddr_t                imem_addr;
  logic                           imem_rvalid;
  logic [8*ifu_pkg::qw_bytes-1:0] imem_rdata;
  ifu_pkg::redir_t                exu_redir;
  logic                           dec_stall;
  logic                           issue_valid;
  ifu_pkg::issue_pkt_t            issue_pkt;

  // program image in halfwords, repeats every 1 KB
  logic [15:0]     prog [mem_half];
  // halfword distance of the jump that starts at each halfword, zero if none
  int              jump_hops [mem_half];
  logic            pending;
  int              lat_cnt;
  ifu_pkg::qaddr_t resp_qa;
  ifu_pkg::pc_t    exp_pc;
  int              consumed;
  int              jumps;
  int              redirects;

  ifu_top ifu_top_i (
    .clk        (clk),
    .reset_sync (reset_sync),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_rvalid(imem_rvalid),
    .imem_rdata (imem_rdata),
    .exu_redir  (exu_redir),
    .dec_stall  (dec_stall),
    .issue_valid(issue_valid),
    .issue_pkt  (issue_pkt)
  );

  bind ifu_top ifu_assertions ifu_assertions_i (
    .clk        (clk),
    .reset_sync (reset_sync),
    .imem_req   (imem_req),
    .imem_rvalid(imem_rvalid),
    .exu_redir  (exu_redir),
    .dec_stall  (dec_stall),
    .issue_valid(issue_valid),
    .issue_pkt  (issue_pkt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (40 * n_instr * max_lat) @(posedge clk);
    fail_run("timeout before all instructions were consumed");
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_issue(input string name, input ifu_pkg::issue_pkt_t exp,
                             input ifu_pkg::issue_pkt_t act);
    if (act !== exp) begin
      fail_run($sformatf("error %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("error %s: expected %b actual %b", name, exp, act));
    end
  endtask

  ////////////////////
  // random program
  task automatic fill_program();
    int          h;
    int          pick;
    int          hops;
    logic [31:0] w;
    logic [11:0] ci;
    logic [20:0] ji;
    h = 0;
    while (h < mem_half) begin
      pick = int'($urandom_range(0, 99));
      hops = int'($urandom_range(0, 96)) - 48;
      if (hops == 0) begin
        hops = 4;
      end
      w = $urandom;
      if (pick < 3) begin
        // c.j a few halfwords away
        ci      = 12'(hops * 2);
        w[15:0] = {3'b101, ci[11], ci[4], ci[9:8], ci[10], ci[6], ci[7], ci[3:1], ci[5],
                   2'b01};
      end else if (pick < 6) begin
        ji = 21'(hops * 2);
        w  = {ji[20], ji[10:1], ji[11], ji[19:12], w[11:7], ifu_pkg::op_jal};
      end else if (pick < 7) begin
        w[15:0] = 16'h0000;
      end else if (pick < 50) begin
        w[1:0] = 2'($urandom_range(0, 2));
        // no accidental c.j with a wild offset
        if (w[1:0] == 2'b01 && w[15:13] == 3'b101) begin
          w[15:13] = 3'b100;
        end
      end else begin
        w[6:0] = op_list[$urandom_range(0, 10)];
      end
      if (w[1:0] != 2'b11) begin
        prog[h]      = w[15:0];
        jump_hops[h] = (pick < 3) ? hops : 0;
        h = h + 1;
      end else if (h < mem_half - 1) begin
        prog[h]          = w[15:0];
        prog[h + 1]      = w[31:16];
        jump_hops[h]     = (pick < 6) ? hops : 0;
        jump_hops[h + 1] = 0;
        h = h + 2;
      end else begin
        prog[h]      = 16'h0001;
        jump_hops[h] = 0;
        h = h + 1;
      end
    end
  endtask

  ////////////////////
  // reference decode
  function automatic ifu_pkg::issue_pkt_t expected_at(input ifu_pkg::pc_t pc);
    ifu_pkg::issue_pkt_t e;
    logic [8:0]          idx;
    logic [31:0]         w;
    idx    = pc[9:1];
    w      = {prog[idx + 9'd1], prog[idx]};
    e      = '0;
    e.pc   = pc;
    e.comp = (w[1:0] != 2'b11);
    if (e.comp) begin
      w         = {16'h0000, w[15:0]};
      e.br      = (w[1:0] == 2'b01) && (w[15:14] == 2'b11);
      e.jal     = (w[1:0] == 2'b01) && (w[15:13] == 3'b101);
      // c.jr and c.jalr
      e.jalr    = (w[1:0] == 2'b10) && (w[15:13] == 3'b100) && (w[11:7] != 5'd0) &&
                  (w[6:2] == 5'd0);
      e.rd      = e.jal ? 5'd0 : w[11:7];
      e.rs1     = w[11:7];
      e.rs2     = w[6:2];
      e.illegal = (w[15:0] == 16'h0000);
    end else begin
      e.br      = (w[6:0] == ifu_pkg::op_branch);
      e.jal     = (w[6:0] == ifu_pkg::op_jal);
      e.jalr    = (w[6:0] == ifu_pkg::op_jalr);
      e.rd      = w[11:7];
      e.rs1     = w[19:15];
      e.rs2     = w[24:20];
      e.illegal = !(w[6:0] inside {ifu_pkg::op_lui, ifu_pkg::op_auipc, ifu_pkg::op_jal,
                                   ifu_pkg::op_jalr, ifu_pkg::op_branch, ifu_pkg::op_load,
                                   ifu_pkg::op_store, ifu_pkg::op_imm, ifu_pkg::op_reg,
                                   ifu_pkg::op_fence, ifu_pkg::op_system}) ||
                  (e.jalr && w[14:12] != 3'b000);
    end
    e.instr = w;
    return e;
  endfunction

  ////////////////////
  // per-cycle stimulus, falling edge
  task automatic serve_memory();
    logic [8:0] base;
    imem_rvalid = 1'b0;
    imem_rdata  = {$urandom, $urandom};
    if (pending) begin
      lat_cnt = lat_cnt - 1;
      if (lat_cnt == 0) begin
        base        = {resp_qa[9:3], 2'b00};
        imem_rdata  = {prog[base + 9'd3], prog[base + 9'd2],
                       prog[base + 9'd1], prog[base]};
        imem_rvalid = 1'b1;
        pending     = 1'b0;
      end
    end
    if (imem_req) begin
      pending = 1'b1;
      resp_qa = imem_addr;
      lat_cnt = int'($urandom_range(1, max_lat));
    end
  endtask

  task automatic run_decode_cycle();
    ifu_pkg::issue_pkt_t exp;
    dec_stall = ($urandom_range(0, 3) == 0);
    exu_redir = '0;
    if ($urandom_range(0, 49) == 0) begin
      exu_redir.valid = 1'b1;
      exu_redir.pc    = ifu_pkg::pc_t'($urandom_range(0, mem_half - 1));
    end
    // consumed at the coming rising edge
    if (issue_valid && !dec_stall) begin
      exp = expected_at(exp_pc);
      check_issue($sformatf("instr %0d", consumed), exp, issue_pkt);
      consumed = consumed + 1;
      if (exp.jal) begin
        exp_pc = exp_pc + ifu_pkg::pc_t'(jump_hops[exp_pc[9:1]]);
        jumps  = jumps + 1;
      end else begin
        exp_pc = exp_pc + (exp.comp ? 31'd1 : 31'd2);
      end
    end
    if (exu_redir.valid) begin
      exp_pc    = exu_redir.pc;
      redirects = redirects + 1;
    end
  endtask

  initial begin
    void'($urandom(10432));
    reset_sync  = 1'b1;
    imem_rvalid = 1'b0;
    imem_rdata  = '0;
    exu_redir   = '0;
    dec_stall   = 1'b0;
    pending     = 1'b0;
    lat_cnt     = 0;
    resp_qa     = '0;
    exp_pc      = '0;
    consumed    = 0;
    jumps       = 0;
    redirects   = 0;
    fill_program();

    repeat (4) @(negedge clk);
    check_bit("reset issue_valid", 1'b0, issue_valid);
    check_bit("reset imem_req", 1'b0, imem_req);
    reset_sync = 1'b0;

    while (consumed < n_instr) begin
      @(negedge clk);
      serve_memory();
      run_decode_cycle();
    end

    $display("consumed %0d instructions, %0d jumps, %0d redirects",
             consumed, jumps, redirects);
    if (jumps > 0 && redirects > 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      fail_run("instruction stream ran without any jump or redirect");
    end
  end

endmodule

`default_nettype wire

/* sim.f */
rtl/ifu_pkg.sv
rtl/ifu_pc_ctrl.sv
rtl/ifu_fetch_queue.sv
rtl/ifu_aligner.sv
rtl/ifu_predecode.sv
rtl/ifu_issue.sv
rtl/ifu_top.sv
verification/ifu_assertions.sv
verification/ifu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ifu_tb -f sim.f -o ifu_sim

./obj_dir/ifu_sim 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
